//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assertions --top-module tb_axi_lite_traffic_master \
		-f axi_lite_traffic_master.f
	./obj_dir/Vtb_axi_lite_traffic_master

clean:
	rm -rf obj_dir

//--- axi_lite_traffic_master.f
+incdir+verilog
verilog/axi_lite_pkg.sv
verilog/traffic_pkg.sv
verilog/lfsr32.sv
verilog/random_pacer.sv
verilog/req_issuer.sv
verilog/ostd_tracker.sv
verilog/axi_lite_traffic_master.sv
tb/axi_lite_slave_model.sv
tb/tb_axi_lite_traffic_master.sv

//--- tb/axi_lite_slave_model.sv
//////////////////////////////////////////////////////////////////////
// Answers with exp_resp and exp_rdata, out of order. One fault per
// corrupt request, and stall withholds every new response
//////////////////////////////////////////////////////////////////////
`include "mst_macros.svh"

module axi_lite_slave_model import axi_lite_pkg::*, traffic_pkg::*; (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   corrupt_b,
    input  logic                   corrupt_r,
    input  logic                   stall,
    input  logic                   awvalid,
    input  logic [`MST_ADDR_W-1:0] awaddr,
    input  logic [`MST_ID_W-1:0]   awid,
    input  logic                   wvalid,
    input  logic                   bready,
    input  logic                   arvalid,
    input  logic [`MST_ADDR_W-1:0] araddr,
    input  logic [`MST_ID_W-1:0]   arid,
    input  logic                   rready,
    output logic                   awready,
    output logic                   wready,
    output logic                   bvalid,
    output logic [`MST_ID_W-1:0]   bid,
    output axi_resp_t              bresp,
    output logic                   b_bad,
    output logic                   arready,
    output logic                   rvalid,
    output logic [`MST_ID_W-1:0]   rid,
    output axi_resp_t              rresp,
    output logic [`MST_DATA_W-1:0] rdata,
    output logic                   r_bad
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`MST_ID_W-1:0]   wq_id [$];
    logic [`MST_ADDR_W-1:0] wq_addr [$];
    logic [`MST_ID_W-1:0]   rq_id [$];
    logic [`MST_ADDR_W-1:0] rq_addr [$];
    logic [31:0]            rnd;
    logic                   b_taken;
    logic                   r_taken;
    logic                   b_used;
    logic                   r_used;
    int                     idx;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Requests and response handshakes are taken at the rising edge
    always @(posedge aclk) begin
        if (aresetn) begin
            if (awvalid && wvalid && awready && wready) begin
                wq_id.push_back(awid);
                wq_addr.push_back(awaddr);
            end
            if (arvalid && arready) begin
                rq_id.push_back(arid);
                rq_addr.push_back(araddr);
            end
            if (bvalid && bready) b_taken = 1'b1;
            if (rvalid && rready) r_taken = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Outputs change on the falling edge only
    //////////////////////////////////////////////////////////////////////
    always @(negedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rnd = 32'd77;
            {awready, wready, arready, bvalid, rvalid, b_bad, r_bad} = '0;
            {b_taken, r_taken, b_used, r_used} = '0;
            bid = '0;
            rid = '0;
            bresp = OKAY;
            rresp = OKAY;
            rdata = '0;
        end else begin
            rnd = xorshift32(rnd);
            awready = rnd[0];
            wready = rnd[1];
            arready = rnd[2];
            if (!bvalid || b_taken) begin
                {bvalid, b_bad, b_taken} = '0;
                if (!stall && wq_id.size() > 0 && rnd[5:4] != 2'b00) begin
                    idx = int'(rnd[15:8]) % wq_id.size();
                    bid = wq_id[idx];
                    bresp = exp_resp(wq_addr[idx]);
                    if (corrupt_b && !b_used) begin
                        bresp = axi_resp_t'(bresp ^ 2'b01);
                        b_bad = 1'b1;
                        b_used = 1'b1;
                    end
                    wq_id.delete(idx);
                    wq_addr.delete(idx);
                    bvalid = 1'b1;
                end
            end
            if (!rvalid || r_taken) begin
                {rvalid, r_bad, r_taken} = '0;
                if (!stall && rq_id.size() > 0 && rnd[7:6] != 2'b00) begin
                    idx = int'(rnd[23:16]) % rq_id.size();
                    rid = rq_id[idx];
                    rresp = exp_resp(rq_addr[idx]);
                    rdata = exp_rdata(rq_addr[idx]);
                    if (corrupt_r && !r_used) begin
                        rdata = rdata ^ `MST_DATA_W'(1);
                        r_bad = 1'b1;
                        r_used = 1'b1;
                    end
                    rq_id.delete(idx);
                    rq_addr.delete(idx);
                    rvalid = 1'b1;
                end
            end
            // Re-arm once the corrupt request is withdrawn
            if (!corrupt_b) b_used = 1'b0;
            if (!corrupt_r) r_used = 1'b0;
        end
    end

endmodule

//--- tb/tb_axi_lite_traffic_master.sv
//////////////////////////////////////////////////////////////////////
// Window is kept 4-byte aligned so clamped addresses stay inside it
//////////////////////////////////////////////////////////////////////
`include "mst_macros.svh"

module tb_axi_lite_traffic_master import axi_lite_pkg::*, traffic_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    logic aclk, aresetn, en, error;
    logic [`MST_ADDR_W-1:0] addr_min, addr_max, awaddr, araddr;
    logic [`MST_ID_W-1:0] awid, bid, arid, rid;
    logic awvalid, awready, wvalid, wready, bvalid, bready, b_bad;
    logic arvalid, arready, rvalid, rready, r_bad;
    logic [`MST_DATA_W-1:0] wdata, rdata;
    logic [`MST_DATA_W/8-1:0] wstrb;
    axi_resp_t bresp, rresp;
    logic corrupt_b, corrupt_r, stall, stall_late;
    int phase, cycles, wr_cnt, rd_cnt;
    logic [`MST_OSTD_NUM-1:0] wr_ids, rd_ids;

    axi_lite_traffic_master UUT (.*);

    axi_lite_slave_model u_slave (.*);

    always #5 aclk = ~aclk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    function automatic logic in_window(input logic [`MST_ADDR_W-1:0] a);
        return a >= addr_min && a <= addr_max && a[1:0] == 2'b00;
    endfunction

    function automatic logic [`MST_OSTD_NUM-1:0] id_bit(input logic fire, input logic [7:0] id);
        return fire ? `MST_OSTD_NUM'(1) << id[1:0] : '0;
    endfunction

    // Own record of outstanding IDs per direction
    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            {wr_ids, rd_ids} <= '0;
            wr_cnt <= 0;
            rd_cnt <= 0;
        end else begin
            wr_ids <= (wr_ids | id_bit(awvalid & awready & wready, awid))
                      & ~id_bit(bvalid & bready, bid);
            rd_ids <= (rd_ids | id_bit(arvalid & arready, arid)) & ~id_bit(rvalid & rready, rid);
            wr_cnt <= wr_cnt + int'(awvalid & awready & wready) - int'(bvalid & bready);
            rd_cnt <= rd_cnt + int'(arvalid & arready) - int'(rvalid & rready);
        end
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) fail_run("Timeout: the run did not finish within 4000 cycles");
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////
    a_aw_req : assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid |-> in_window(awaddr) && awid inside {[16:19]} && !wr_ids[awid[1:0]])
        else fail_run($sformatf("** Error at %0t: awaddr/awid = %h/%h, expected [%h:%h]/free ID",
                                $time, awaddr, awid, addr_min, addr_max));
    a_ar_req : assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid |-> in_window(araddr) && arid inside {[16:19]} && !rd_ids[arid[1:0]])
        else fail_run($sformatf("** Error at %0t: araddr/arid = %h/%h, expected [%h:%h]/free ID",
                                $time, araddr, arid, addr_min, addr_max));
    a_w_fields : assert property (@(posedge aclk) awvalid == wvalid && wstrb == wdata[1:0])
        else fail_run($sformatf("** Error at %0t: wvalid/wstrb = %b/%b, expected %b/%b",
                                $time, wvalid, wstrb, awvalid, wdata[1:0]));
    a_aw_hold : assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid && !(awready && wready) |=> awvalid && $stable(awaddr) && $stable(awid))
        else fail_run("Write request changed or dropped before its handshake");
    a_ar_hold : assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
        else fail_run("Read request changed or dropped before its handshake");
    a_en_low_wr : assert property (@(posedge aclk) disable iff (!aresetn)
        !en && !awvalid |=> !awvalid)
        else fail_run("A new write request was raised while en was low");
    a_en_low_rd : assert property (@(posedge aclk) disable iff (!aresetn)
        !en && !arvalid |=> !arvalid)
        else fail_run("A new read request was raised while en was low");
    a_ostd : assert property (@(posedge aclk) wr_cnt <= 4 && rd_cnt <= 4)
        else fail_run($sformatf("** Error at %0t: outstanding wr/rd = %0d/%0d, expected <= 4",
                                $time, wr_cnt, rd_cnt));
    a_clean : assert property (@(posedge aclk) disable iff (!aresetn) phase == 1 |-> !error)
        else fail_run($sformatf("** Error at %0t: error = %b, expected 0", $time, error));
    a_b_pulse : assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid && bready && b_bad |=> error ##1 !error)
        else fail_run($sformatf("** Error at %0t: error = %b after bad BRESP, expected pulse",
                                $time, error));
    a_r_pulse : assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && rready && r_bad |=> error ##1 !error)
        else fail_run($sformatf("** Error at %0t: error = %b after bad RDATA, expected pulse",
                                $time, error));
    a_stall : assert property (@(posedge aclk) stall_late |-> error)
        else fail_run($sformatf("** Error at %0t: error = %b in stall, expected 1", $time, error));
    a_reset_idle : assert property (@(posedge aclk)
        $rose(aresetn) |-> !awvalid && !arvalid && !bready && !rready && !error)
        else fail_run("A valid, ready or error output was high right after reset");

    initial begin
        aclk = 1'b0;
        cycles = 0;
        {aresetn, en, corrupt_b, corrupt_r, stall, stall_late} = '0;
        addr_min = 8'h20;
        addr_max = 8'h9C;
        phase = 0;
        repeat (3) @(negedge aclk);
        aresetn = 1'b1;
        phase = 1;
        // Clean traffic with en dropped for stretches
        for (int i = 0; i < 1500; i++) begin
            en = (i % 300) < 240;
            @(negedge aclk);
        end
        en = 1'b1;
        phase = 2;
        corrupt_b = 1'b1;
        do @(posedge aclk); while (!(bvalid && bready && b_bad));
        @(negedge aclk);
        corrupt_b = 1'b0;
        repeat (5) @(negedge aclk);
        phase = 3;
        corrupt_r = 1'b1;
        do @(posedge aclk); while (!(rvalid && rready && r_bad));
        @(negedge aclk);
        corrupt_r = 1'b0;
        repeat (5) @(negedge aclk);
        phase = 4;
        stall = 1'b1;
        repeat (`MST_TIMEOUT + 20) @(negedge aclk);
        stall_late = 1'b1;
        repeat (10) @(negedge aclk);
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- verilog/axi_lite_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI4-lite response codes only
//////////////////////////////////////////////////////////////////////
package axi_lite_pkg;

    // Encoding follows the AXI spec
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

endpackage

//--- verilog/axi_lite_traffic_master.sv
//////////////////////////////////////////////////////////////////////
// AW and W are always issued together, len/burst signals are absent
//////////////////////////////////////////////////////////////////////
`include "mst_macros.svh"

module axi_lite_traffic_master import axi_lite_pkg::*, traffic_pkg::*; (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     en,
    input  logic [`MST_ADDR_W-1:0]   addr_min,
    input  logic [`MST_ADDR_W-1:0]   addr_max,
    output logic                     error,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [`MST_ADDR_W-1:0]   awaddr,
    output logic [`MST_ID_W-1:0]     awid,
    output logic                     wvalid,
    input  logic                     wready,
    output logic [`MST_DATA_W-1:0]   wdata,
    output logic [`MST_DATA_W/8-1:0] wstrb,
    input  logic                     bvalid,
    output logic                     bready,
    input  logic [`MST_ID_W-1:0]     bid,
    input  axi_resp_t                bresp,
    output logic                     arvalid,
    input  logic                     arready,
    output logic [`MST_ADDR_W-1:0]   araddr,
    output logic [`MST_ID_W-1:0]     arid,
    input  logic                     rvalid,
    output logic                     rready,
    input  logic [`MST_ID_W-1:0]     rid,
    input  axi_resp_t                rresp,
    input  logic [`MST_DATA_W-1:0]   rdata
);

    localparam int SLOT_W = $clog2(`MST_OSTD_NUM);

    logic                     wr_fire;
    logic                     rd_fire;
    logic [SLOT_W-1:0]        wr_slot;
    logic [SLOT_W-1:0]        rd_slot;
    logic [`MST_OSTD_NUM-1:0] wr_busy;
    logic [`MST_OSTD_NUM-1:0] rd_busy;
    lfsr_word_u               wr_word;
    lfsr_word_u               rd_word;
    logic                     wr_mismatch;
    logic                     rd_mismatch;
    logic                     wr_timed_out;
    logic                     rd_timed_out;

    //////////////////////////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////////////////////////

    assign wvalid = awvalid;

    req_issuer u_wr_issuer (
        .aclk (aclk), .aresetn (aresetn), .en (en),
        .ready    (awready & wready),
        .addr_min (addr_min), .addr_max (addr_max), .busy (wr_busy),
        .valid (awvalid), .fire (wr_fire), .slot (wr_slot),
        .addr (awaddr), .id (awid), .data (wdata), .strb (wstrb),
        .word (wr_word)
    );

    ostd_tracker #(.CHECK_DATA(0)) u_wr_tracker (
        .aclk (aclk), .aresetn (aresetn),
        .fire (wr_fire), .slot (wr_slot), .req_addr (awaddr), .req_id (awid),
        .rsp_fire (bvalid & bready), .rsp_id (bid), .rsp_resp (bresp),
        .rsp_data ('0),
        .busy (wr_busy), .mismatch (wr_mismatch), .timed_out (wr_timed_out)
    );

    random_pacer u_b_pacer (
        .aclk (aclk), .aresetn (aresetn),
        .fire (bvalid & bready), .word (wr_word), .strobe (bready)
    );

    //////////////////////////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////////////////////////

    req_issuer u_rd_issuer (
        .aclk (aclk), .aresetn (aresetn), .en (en),
        .ready    (arready),
        .addr_min (addr_min), .addr_max (addr_max), .busy (rd_busy),
        .valid (arvalid), .fire (rd_fire), .slot (rd_slot),
        .addr (araddr), .id (arid), .data (), .strb (),
        .word (rd_word)
    );

    ostd_tracker #(.CHECK_DATA(1)) u_rd_tracker (
        .aclk (aclk), .aresetn (aresetn),
        .fire (rd_fire), .slot (rd_slot), .req_addr (araddr), .req_id (arid),
        .rsp_fire (rvalid & rready), .rsp_id (rid), .rsp_resp (rresp),
        .rsp_data (rdata),
        .busy (rd_busy), .mismatch (rd_mismatch), .timed_out (rd_timed_out)
    );

    random_pacer u_r_pacer (
        .aclk (aclk), .aresetn (aresetn),
        .fire (rvalid & rready), .word (rd_word), .strobe (rready)
    );

    // Mismatch pulses for one cycle, timeout holds until release
    assign error = wr_mismatch | rd_mismatch | wr_timed_out | rd_timed_out;

endmodule

//--- verilog/lfsr32.sv
//////////////////////////////////////////////////////////////////////
// Seed must be non-zero, an all-zero state never leaves zero
//////////////////////////////////////////////////////////////////////
`include "mst_macros.svh"

module lfsr32 (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        en,
    output logic [31:0] lfsr
);

    // x^32 + x^22 + x^2 + x + 1, right-shifting Galois form
    localparam logic [31:0] TAPS = 32'h8020_0003;

    logic [31:0] next;

    always_comb begin
        next = {1'b0, lfsr[31:1]};
        if (lfsr[0]) begin
            next = next ^ TAPS;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lfsr <= `MST_LFSR_KEY;
        end else if (en) begin
            lfsr <= next;
        end
    end

endmodule

//--- verilog/mst_macros.svh
//////////////////////////////////////////////////////////////////////
// Values are shared by RTL and testbench. Slot count must be a power
// of two for the ID counter wrap, and widths must fit one LFSR word
//////////////////////////////////////////////////////////////////////
`ifndef MST_MACROS_SVH
`define MST_MACROS_SVH

// Bus widths
`define MST_ADDR_W 8
`define MST_DATA_W 16
`define MST_ID_W 8

// Outstanding slots per direction
`define MST_OSTD_NUM 4

// First ID issued, the others follow it
`define MST_ID 16

`define MST_LFSR_KEY 32'hFFFF_FFFF
`define MST_TIMEOUT 100

`endif

//--- verilog/ostd_tracker.sv
//////////////////////////////////////////////////////////////////////
// IDs of busy slots are assumed unique, as the issuer guarantees
//////////////////////////////////////////////////////////////////////
`include "mst_macros.svh"

module ostd_tracker import axi_lite_pkg::*, traffic_pkg::*; #(
    // 0 checks the response code, 1 also checks the data
    parameter int CHECK_DATA = 0
) (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  logic                             fire,
    input  logic [$clog2(`MST_OSTD_NUM)-1:0] slot,
    input  logic [`MST_ADDR_W-1:0]           req_addr,
    input  logic [`MST_ID_W-1:0]             req_id,
    input  logic                             rsp_fire,
    input  logic [`MST_ID_W-1:0]             rsp_id,
    input  axi_resp_t                        rsp_resp,
    input  logic [`MST_DATA_W-1:0]           rsp_data,
    output logic [`MST_OSTD_NUM-1:0]         busy,
    output logic                             mismatch,
    output logic                             timed_out
);

    localparam int N     = `MST_OSTD_NUM;
    localparam int AGE_W = $clog2(`MST_TIMEOUT + 2);

    logic [`MST_ID_W-1:0] slot_id   [N];
    axi_resp_t            slot_resp [N];
    logic [AGE_W-1:0]     age       [N];
    logic [N-1:0]         hit;
    logic [N-1:0]         bad;
    logic [N-1:0]         data_bad;
    logic [N-1:0]         over;

    //////////////////////////////////////////////////////////////////////
    // Expectation storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (fire) begin
            slot_id[slot]   <= req_id;
            slot_resp[slot] <= exp_resp(req_addr);
        end
    end

    if (CHECK_DATA != 0) begin : g_data
        logic [`MST_DATA_W-1:0] slot_data [N];

        always_ff @(posedge aclk) begin
            if (fire) begin
                slot_data[slot] <= exp_rdata(req_addr);
            end
        end
        for (genvar i = 0; i < N; i++) begin : g_cmp
            assign data_bad[i] = slot_data[i] != rsp_data;
        end
    end else begin : g_no_data
        assign data_bad = '0;
    end

    //////////////////////////////////////////////////////////////////////
    // Release, check and age
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < N; i++) begin : g_slot
        assign hit[i]  = rsp_fire && busy[i] && slot_id[i] == rsp_id;
        assign bad[i]  = (slot_resp[i] != rsp_resp) || data_bad[i];
        assign over[i] = busy[i] && age[i] > AGE_W'(`MST_TIMEOUT);

        always_ff @(posedge aclk or negedge aresetn) begin
            if (!aresetn) begin
                busy[i] <= 1'b0;
                age[i]  <= '0;
            end else begin
                if (fire && slot == i) begin
                    busy[i] <= 1'b1;
                end else if (hit[i]) begin
                    busy[i] <= 1'b0;
                end
                // Saturates one past the limit
                if (!busy[i] || hit[i]) begin
                    age[i] <= '0;
                end else if (!over[i]) begin
                    age[i] <= age[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mismatch <= 1'b0;
        end else begin
            mismatch <= |(hit & bad);
        end
    end

    assign timed_out = |over;

    // Issuer must wait for a free slot before its handshake
    a_no_overwrite : assert property (
        @(posedge aclk) disable iff (!aresetn)
        fire |-> !busy[slot]
    );

endmodule

//--- verilog/random_pacer.sv
//////////////////////////////////////////////////////////////////////
// Strobe stays high until fire, so it suits valid and ready alike
//////////////////////////////////////////////////////////////////////
module random_pacer import traffic_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       fire,
    input  lfsr_word_u word,
    output logic       strobe
);

    logic [31:0] hold;

    assign strobe = hold[0];

    // Zero bits delay the strobe, the first set bit raises it
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            hold <= '0;
        end else if (fire || hold == '0) begin
            hold <= word.raw;
        end else if (!strobe) begin
            hold <= hold >> 1;
        end
    end

    // The LFSR feeding this pacer never produces a zero word
    a_hold_reloads : assert property (
        @(posedge aclk) disable iff (!aresetn)
        hold == '0 |=> hold != '0
    );

endmodule

//--- verilog/req_issuer.sv
//////////////////////////////////////////////////////////////////////
// addr_min and addr_max are taken as static with addr_min <= addr_max
//////////////////////////////////////////////////////////////////////
`include "mst_macros.svh"

module req_issuer import traffic_pkg::*; (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            en,
    input  logic                            ready,
    input  logic [`MST_ADDR_W-1:0]          addr_min,
    input  logic [`MST_ADDR_W-1:0]          addr_max,
    input  logic [`MST_OSTD_NUM-1:0]        busy,
    output logic                            valid,
    output logic                            fire,
    output logic [$clog2(`MST_OSTD_NUM)-1:0] slot,
    output logic [`MST_ADDR_W-1:0]          addr,
    output logic [`MST_ID_W-1:0]            id,
    output logic [`MST_DATA_W-1:0]          data,
    output logic [`MST_DATA_W/8-1:0]        strb,
    output lfsr_word_u                      word
);

    logic                   pending;
    logic                   strobe;
    logic [`MST_ADDR_W-1:0] clamped;

    assign valid = pending;
    assign fire  = pending & ready;

    // The LFSR only steps on a handshake, so the payload holds while waiting
    lfsr32 u_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .en      (fire),
        .lfsr    (word)
    );

    random_pacer u_pacer (
        .aclk    (aclk),
        .aresetn (aresetn),
        .fire    (fire),
        .word    (word),
        .strobe  (strobe)
    );

    // Clamp into the window, then force 4-byte alignment
    assign clamped = (word.f.addr > addr_max) ? addr_max :
                     (word.f.addr < addr_min) ? addr_min : word.f.addr;
    assign addr = {clamped[`MST_ADDR_W-1:2], 2'b00};

    assign id   = `MST_ID_W'(`MST_ID) + `MST_ID_W'(slot);
    assign data = word.f.data;
    assign strb = word.f.data[`MST_DATA_W/8-1:0];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pending <= 1'b0;
            slot    <= '0;
        end else begin
            if (fire) begin
                pending <= 1'b0;
            end else if (strobe && en && !busy[slot]) begin
                pending <= 1'b1;
            end
            // ID counter wraps over the slot count
            if (fire) begin
                slot <= slot + 1'b1;
            end
        end
    end

    a_valid_stable : assert property (
        @(posedge aclk) disable iff (!aresetn)
        valid && !ready |=> valid && $stable(addr) && $stable(id)
    );

endmodule

//--- verilog/traffic_pkg.sv
//////////////////////////////////////////////////////////////////////
// Slaves must answer with exp_resp and exp_rdata for a clean run
//////////////////////////////////////////////////////////////////////
`include "mst_macros.svh"

package traffic_pkg;

    import axi_lite_pkg::*;

    // One LFSR word, seen as raw bits by pacers and as fields by issuers
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [7:0]             pad;
            logic [`MST_ADDR_W-1:0] addr;
            logic [`MST_DATA_W-1:0] data;
        } f;
    } lfsr_word_u;

    // Expected response code is taken from address bits 3:2
    function automatic axi_resp_t exp_resp(input logic [`MST_ADDR_W-1:0] addr);
        return axi_resp_t'(addr[3:2]);
    endfunction

    // Expected read data is the address and its inverse
    function automatic logic [`MST_DATA_W-1:0] exp_rdata(
        input logic [`MST_ADDR_W-1:0] addr
    );
        return {addr, ~addr};
    endfunction

endpackage
